// File: afu_params.svh
// AFU shared constants
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// Memory tags, tag 0 is the WED fetch
`define AFU_TAGS      8
`define AFU_TAG_BITS  3
`define AFU_ADDR_BITS 24
`define AFU_DATA_BITS 64

// Job opcodes in bits 63:60
`define AFU_OP_START   4'd1
`define AFU_OP_CONTROL 4'd2

// WED word layout
`define AFU_WED_SRC_HI 63
`define AFU_WED_SRC_LO 40
`define AFU_WED_DST_HI 39
`define AFU_WED_DST_LO 16
`define AFU_WED_CNT_HI 15
`define AFU_WED_CNT_LO 0

// MMIO read map
`define AFU_MMIO_ADDR_BITS 2
`define AFU_MMIO_STATUS    2'd0
`define AFU_MMIO_SUM       2'd1
`define AFU_MMIO_JOBS      2'd2

// Status word bits
`define AFU_ERR_OPCODE   0
`define AFU_ERR_RESPONSE 1
`define AFU_STATUS_DONE  2

`endif

// File: afu_pkg.sv
// AFU shared types
package afu_pkg;

  `include "afu_params.svh"

  //////////////////////////////
  // Job word views
  //////////////////////////////

  // Start word carries the WED address
  typedef struct packed {
    logic [3:0]                opcode;
    logic [35:0]               reserved;
    logic [`AFU_ADDR_BITS-1:0] wed_addr;
  } job_start_t;

  // Control word carries the clear flags
  typedef struct packed {
    logic [3:0]  opcode;
    logic [57:0] reserved;
    logic        clear_result;
    logic        clear_errors;
  } job_control_t;

  // Opcode sits in the same top bits in both views
  typedef union packed {
    job_start_t   start;
    job_control_t control;
  } job_word_t;

  typedef logic [`AFU_TAG_BITS-1:0] tag_t;

endpackage

// File: job_decode.sv
// Job decode and WED fetch
`timescale 1ns/1ps
`include "afu_params.svh"

module job_decode import afu_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      job_valid,
  output logic                      job_ready,
  input  job_word_t                 job_word,
  output logic                      wed_cmd_valid,
  input  logic                      wed_cmd_ready,
  output logic [`AFU_ADDR_BITS-1:0] wed_cmd_addr,
  input  logic                      wed_rsp_valid,
  input  logic [`AFU_DATA_BITS-1:0] wed_rsp_data,
  output logic                      cu_start,
  output logic [`AFU_ADDR_BITS-1:0] src_addr,
  output logic [`AFU_ADDR_BITS-1:0] dst_addr,
  output logic [15:0]               word_count,
  input  logic                      cu_done,
  output logic                      bad_opcode,
  output logic                      clear_errors,
  output logic                      clear_result
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_RUN
  } state_t;

  state_t state;
  logic   accept;
  logic   is_start;
  logic   is_control;

  assign is_start   = job_word.start.opcode == `AFU_OP_START;
  assign is_control = job_word.control.opcode == `AFU_OP_CONTROL;

  // Only a new start word waits for the current job
  assign job_ready = !(state != S_IDLE && is_start);
  assign accept    = job_valid && job_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= S_IDLE;
      wed_cmd_valid <= 1'b0;
      cu_start      <= 1'b0;
      bad_opcode    <= 1'b0;
      clear_errors  <= 1'b0;
      clear_result  <= 1'b0;
    end else begin
      cu_start     <= 1'b0;
      bad_opcode   <= accept && !is_start && !is_control;
      clear_errors <= accept && is_control && job_word.control.clear_errors;
      clear_result <= accept && is_control && job_word.control.clear_result;
      case (state)
        S_IDLE: begin
          if (accept && is_start) begin
            state         <= S_FETCH;
            wed_cmd_valid <= 1'b1;
          end
        end
        S_FETCH: begin
          if (wed_cmd_valid && wed_cmd_ready) begin
            wed_cmd_valid <= 1'b0;
          end
          // WED is in, hand the job to the compute unit
          if (wed_rsp_valid) begin
            state    <= S_RUN;
            cu_start <= 1'b1;
          end
        end
        S_RUN: begin
          if (cu_done) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // WED address and fields
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (accept && is_start) begin
      wed_cmd_addr <= job_word.start.wed_addr;
    end
    if (state == S_FETCH && wed_rsp_valid) begin
      src_addr   <= wed_rsp_data[`AFU_WED_SRC_HI:`AFU_WED_SRC_LO];
      dst_addr   <= wed_rsp_data[`AFU_WED_DST_HI:`AFU_WED_DST_LO];
      word_count <= wed_rsp_data[`AFU_WED_CNT_HI:`AFU_WED_CNT_LO];
    end
  end

endmodule

// File: command_arbiter.sv
// Memory command arbiter
`timescale 1ns/1ps
`include "afu_params.svh"

module command_arbiter import afu_pkg::*; (
  // WED source, tag 0
  input  logic                      wed_cmd_valid,
  output logic                      wed_cmd_ready,
  input  logic [`AFU_ADDR_BITS-1:0] wed_cmd_addr,
  output logic                      wed_rsp_valid,
  output logic [`AFU_DATA_BITS-1:0] wed_rsp_data,
  // Compute unit source
  input  logic                      cu_cmd_valid,
  output logic                      cu_cmd_ready,
  input  logic                      cu_cmd_write,
  input  logic [`AFU_ADDR_BITS-1:0] cu_cmd_addr,
  input  tag_t                      cu_cmd_tag,
  input  logic [`AFU_DATA_BITS-1:0] cu_cmd_data,
  output logic                      cu_rsp_valid,
  output tag_t                      cu_rsp_tag,
  output logic [`AFU_DATA_BITS-1:0] cu_rsp_data,
  // Memory port
  output logic                      mem_cmd_valid,
  input  logic                      mem_cmd_ready,
  output logic                      mem_cmd_write,
  output logic [`AFU_ADDR_BITS-1:0] mem_cmd_addr,
  output tag_t                      mem_cmd_tag,
  output logic [`AFU_DATA_BITS-1:0] mem_cmd_data,
  input  logic                      mem_rsp_valid,
  input  tag_t                      mem_rsp_tag,
  input  logic [`AFU_DATA_BITS-1:0] mem_rsp_data,
  input  logic                      mem_rsp_error,
  output logic                      rsp_error
);

  logic wed_tag;

  //////////////////////////////
  // Commands, WED first
  //////////////////////////////

  assign mem_cmd_valid = wed_cmd_valid || cu_cmd_valid;
  assign mem_cmd_write = wed_cmd_valid ? 1'b0 : cu_cmd_write;
  assign mem_cmd_addr  = wed_cmd_valid ? wed_cmd_addr : cu_cmd_addr;
  assign mem_cmd_tag   = wed_cmd_valid ? tag_t'(0) : cu_cmd_tag;
  assign mem_cmd_data  = wed_cmd_valid ? '0 : cu_cmd_data;

  // Losing source sees ready low and holds
  assign wed_cmd_ready = mem_cmd_ready;
  assign cu_cmd_ready  = mem_cmd_ready && !wed_cmd_valid;

  //////////////////////////////
  // Responses by tag
  //////////////////////////////

  assign wed_tag       = mem_rsp_tag == tag_t'(0);
  assign wed_rsp_valid = mem_rsp_valid && wed_tag;
  assign wed_rsp_data  = mem_rsp_data;
  assign cu_rsp_valid  = mem_rsp_valid && !wed_tag;
  assign cu_rsp_tag    = mem_rsp_tag;
  assign cu_rsp_data   = mem_rsp_data;

  // Any response may carry an error
  assign rsp_error = mem_rsp_valid && mem_rsp_error;

endmodule

// File: cu_execute.sv
// Compute unit, tagged reads and sum
`timescale 1ns/1ps
`include "afu_params.svh"

module cu_execute import afu_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      cu_start,
  input  logic [`AFU_ADDR_BITS-1:0] src_addr,
  input  logic [`AFU_ADDR_BITS-1:0] dst_addr,
  input  logic [15:0]               word_count,
  output logic                      cu_cmd_valid,
  input  logic                      cu_cmd_ready,
  output logic                      cu_cmd_write,
  output logic [`AFU_ADDR_BITS-1:0] cu_cmd_addr,
  output tag_t                      cu_cmd_tag,
  output logic [`AFU_DATA_BITS-1:0] cu_cmd_data,
  input  logic                      cu_rsp_valid,
  input  tag_t                      cu_rsp_tag,
  input  logic [`AFU_DATA_BITS-1:0] cu_rsp_data,
  output logic                      cu_done,
  output logic [`AFU_DATA_BITS-1:0] sum
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WRITE,
    S_WAIT
  } state_t;

  state_t                    state;
  logic [`AFU_TAGS-1:0]      busy;
  logic [`AFU_TAGS-1:0]      set_mask;
  logic [`AFU_TAGS-1:0]      clr_mask;
  logic [15:0]               issued;
  logic [15:0]               received;
  tag_t                      free_tag;
  logic                      have_free;
  logic                      load_read;
  logic                      load_write;

  // Lowest free tag among 1 to 7, tag 0 never set busy
  always_comb begin
    free_tag  = tag_t'(0);
    have_free = 1'b0;
    for (int t = `AFU_TAGS - 1; t >= 1; t--) begin
      if (!busy[t]) begin
        free_tag  = tag_t'(t);
        have_free = 1'b1;
      end
    end
  end

  assign load_read  = state == S_READ && !cu_cmd_valid && issued != word_count && have_free;
  assign load_write = state == S_READ && !cu_cmd_valid && issued == word_count
                      && received == word_count;

  // Tag reserved at load, freed by its response
  assign set_mask = load_read ? (`AFU_TAGS'(1) << free_tag) : '0;
  assign clr_mask = (state == S_READ && cu_rsp_valid) ? (`AFU_TAGS'(1) << cu_rsp_tag) : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= S_IDLE;
      cu_cmd_valid <= 1'b0;
      busy         <= '0;
      issued       <= '0;
      received     <= '0;
      cu_done      <= 1'b0;
      sum          <= '0;
    end else begin
      cu_done <= 1'b0;
      busy    <= (busy | set_mask) & ~clr_mask;
      if (cu_cmd_valid && cu_cmd_ready) begin
        cu_cmd_valid <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (cu_start) begin
            state    <= S_READ;
            issued   <= '0;
            received <= '0;
            sum      <= '0;
          end
        end
        S_READ: begin
          if (cu_rsp_valid) begin
            sum      <= sum + cu_rsp_data;
            received <= received + 16'd1;
          end
          if (load_read) begin
            cu_cmd_valid <= 1'b1;
            issued       <= issued + 16'd1;
          end else if (load_write) begin
            cu_cmd_valid <= 1'b1;
            state        <= S_WRITE;
          end
        end
        S_WRITE: begin
          if (cu_cmd_valid && cu_cmd_ready) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (cu_rsp_valid) begin
            state   <= S_IDLE;
            cu_done <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Command payload
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (load_read) begin
      cu_cmd_write <= 1'b0;
      cu_cmd_addr  <= src_addr + `AFU_ADDR_BITS'(issued);
      cu_cmd_tag   <= free_tag;
      cu_cmd_data  <= '0;
    end else if (load_write) begin
      // All tags are free by now
      cu_cmd_write <= 1'b1;
      cu_cmd_addr  <= dst_addr;
      cu_cmd_tag   <= free_tag;
      cu_cmd_data  <= sum;
    end
  end

endmodule

// File: result_control.sv
// Done, errors and MMIO reads
`timescale 1ns/1ps
`include "afu_params.svh"

module result_control (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           cu_done,
  input  logic [`AFU_DATA_BITS-1:0]      sum,
  input  logic                           bad_opcode,
  input  logic                           rsp_error,
  input  logic                           clear_errors,
  input  logic                           clear_result,
  output logic                           job_done,
  input  logic                           mmio_read,
  input  logic [`AFU_MMIO_ADDR_BITS-1:0] mmio_addr,
  output logic                           mmio_rdata_valid,
  output logic [`AFU_DATA_BITS-1:0]      mmio_rdata
);

  logic [`AFU_DATA_BITS-1:0] result_sum;
  logic [`AFU_DATA_BITS-1:0] job_count;
  logic [`AFU_DATA_BITS-1:0] status;
  logic [1:0]                errors;
  logic                      done_flag;

  //////////////////////////////
  // Result and job counter
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      job_done   <= 1'b0;
      result_sum <= '0;
      job_count  <= '0;
      done_flag  <= 1'b0;
    end else begin
      job_done <= cu_done;
      if (clear_result) begin
        result_sum <= '0;
        job_count  <= '0;
        done_flag  <= 1'b0;
      end
      // A finishing job wins over a clear
      if (cu_done) begin
        result_sum <= sum;
        job_count  <= job_count + 1'b1;
        done_flag  <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Sticky errors
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      errors <= '0;
    end else begin
      if (clear_errors) begin
        errors <= '0;
      end
      if (bad_opcode) begin
        errors[`AFU_ERR_OPCODE] <= 1'b1;
      end
      if (rsp_error) begin
        errors[`AFU_ERR_RESPONSE] <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // MMIO read port
  //////////////////////////////

  always_comb begin
    status                    = '0;
    status[1:0]               = errors;
    status[`AFU_STATUS_DONE]  = done_flag;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mmio_rdata_valid <= 1'b0;
    end else begin
      mmio_rdata_valid <= mmio_read;
    end
  end

  // Unknown addresses read zero
  always_ff @(posedge clock) begin
    if (mmio_read) begin
      case (mmio_addr)
        `AFU_MMIO_STATUS: mmio_rdata <= status;
        `AFU_MMIO_SUM:    mmio_rdata <= result_sum;
        `AFU_MMIO_JOBS:   mmio_rdata <= job_count;
        default:          mmio_rdata <= '0;
      endcase
    end
  end

endmodule

// File: afu_top.sv
// Accelerator functional unit top
`timescale 1ns/1ps
`include "afu_params.svh"

module afu_top import afu_pkg::*; (
  input  logic                           clock,
  input  logic                           reset,
  // Job port
  input  logic                           job_valid,
  output logic                           job_ready,
  input  job_word_t                      job_word,
  output logic                           job_done,
  // Memory port
  output logic                           mem_cmd_valid,
  input  logic                           mem_cmd_ready,
  output logic                           mem_cmd_write,
  output logic [`AFU_ADDR_BITS-1:0]      mem_cmd_addr,
  output tag_t                           mem_cmd_tag,
  output logic [`AFU_DATA_BITS-1:0]      mem_cmd_data,
  input  logic                           mem_rsp_valid,
  input  tag_t                           mem_rsp_tag,
  input  logic [`AFU_DATA_BITS-1:0]      mem_rsp_data,
  input  logic                           mem_rsp_error,
  // MMIO port
  input  logic                           mmio_read,
  input  logic [`AFU_MMIO_ADDR_BITS-1:0] mmio_addr,
  output logic                           mmio_rdata_valid,
  output logic [`AFU_DATA_BITS-1:0]      mmio_rdata
);

  logic                      wed_cmd_valid;
  logic                      wed_cmd_ready;
  logic [`AFU_ADDR_BITS-1:0] wed_cmd_addr;
  logic                      wed_rsp_valid;
  logic [`AFU_DATA_BITS-1:0] wed_rsp_data;
  logic                      cu_start;
  logic [`AFU_ADDR_BITS-1:0] src_addr;
  logic [`AFU_ADDR_BITS-1:0] dst_addr;
  logic [15:0]               word_count;
  logic                      cu_done;
  logic                      cu_cmd_valid;
  logic                      cu_cmd_ready;
  logic                      cu_cmd_write;
  logic [`AFU_ADDR_BITS-1:0] cu_cmd_addr;
  tag_t                      cu_cmd_tag;
  logic [`AFU_DATA_BITS-1:0] cu_cmd_data;
  logic                      cu_rsp_valid;
  tag_t                      cu_rsp_tag;
  logic [`AFU_DATA_BITS-1:0] cu_rsp_data;
  logic [`AFU_DATA_BITS-1:0] sum;
  logic                      bad_opcode;
  logic                      clear_errors;
  logic                      clear_result;
  logic                      rsp_error;

  //////////////////////////////
  // Decode
  //////////////////////////////

  job_decode job_decode_inst (
    .clock        (clock),
    .reset        (reset),
    .job_valid    (job_valid),
    .job_ready    (job_ready),
    .job_word     (job_word),
    .wed_cmd_valid(wed_cmd_valid),
    .wed_cmd_ready(wed_cmd_ready),
    .wed_cmd_addr (wed_cmd_addr),
    .wed_rsp_valid(wed_rsp_valid),
    .wed_rsp_data (wed_rsp_data),
    .cu_start     (cu_start),
    .src_addr     (src_addr),
    .dst_addr     (dst_addr),
    .word_count   (word_count),
    .cu_done      (cu_done),
    .bad_opcode   (bad_opcode),
    .clear_errors (clear_errors),
    .clear_result (clear_result)
  );

  //////////////////////////////
  // Memory commands
  //////////////////////////////

  command_arbiter command_arbiter_inst (
    .wed_cmd_valid(wed_cmd_valid),
    .wed_cmd_ready(wed_cmd_ready),
    .wed_cmd_addr (wed_cmd_addr),
    .wed_rsp_valid(wed_rsp_valid),
    .wed_rsp_data (wed_rsp_data),
    .cu_cmd_valid (cu_cmd_valid),
    .cu_cmd_ready (cu_cmd_ready),
    .cu_cmd_write (cu_cmd_write),
    .cu_cmd_addr  (cu_cmd_addr),
    .cu_cmd_tag   (cu_cmd_tag),
    .cu_cmd_data  (cu_cmd_data),
    .cu_rsp_valid (cu_rsp_valid),
    .cu_rsp_tag   (cu_rsp_tag),
    .cu_rsp_data  (cu_rsp_data),
    .mem_cmd_valid(mem_cmd_valid),
    .mem_cmd_ready(mem_cmd_ready),
    .mem_cmd_write(mem_cmd_write),
    .mem_cmd_addr (mem_cmd_addr),
    .mem_cmd_tag  (mem_cmd_tag),
    .mem_cmd_data (mem_cmd_data),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_tag  (mem_rsp_tag),
    .mem_rsp_data (mem_rsp_data),
    .mem_rsp_error(mem_rsp_error),
    .rsp_error    (rsp_error)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  cu_execute cu_execute_inst (
    .clock       (clock),
    .reset       (reset),
    .cu_start    (cu_start),
    .src_addr    (src_addr),
    .dst_addr    (dst_addr),
    .word_count  (word_count),
    .cu_cmd_valid(cu_cmd_valid),
    .cu_cmd_ready(cu_cmd_ready),
    .cu_cmd_write(cu_cmd_write),
    .cu_cmd_addr (cu_cmd_addr),
    .cu_cmd_tag  (cu_cmd_tag),
    .cu_cmd_data (cu_cmd_data),
    .cu_rsp_valid(cu_rsp_valid),
    .cu_rsp_tag  (cu_rsp_tag),
    .cu_rsp_data (cu_rsp_data),
    .cu_done     (cu_done),
    .sum         (sum)
  );

  //////////////////////////////
  // Result and MMIO
  //////////////////////////////

  result_control result_control_inst (
    .clock           (clock),
    .reset           (reset),
    .cu_done         (cu_done),
    .sum             (sum),
    .bad_opcode      (bad_opcode),
    .rsp_error       (rsp_error),
    .clear_errors    (clear_errors),
    .clear_result    (clear_result),
    .job_done        (job_done),
    .mmio_read       (mmio_read),
    .mmio_addr       (mmio_addr),
    .mmio_rdata_valid(mmio_rdata_valid),
    .mmio_rdata      (mmio_rdata)
  );

endmodule

// File: afu_assertions.sv
// AFU protocol assertions
`timescale 1ns/1ps
`include "afu_params.svh"

module afu_assertions import afu_pkg::*; (
  input logic                      clock,
  input logic                      reset,
  input logic                      mem_cmd_valid,
  input logic                      mem_cmd_ready,
  input logic                      mem_cmd_write,
  input logic [`AFU_ADDR_BITS-1:0] mem_cmd_addr,
  input tag_t                      mem_cmd_tag,
  input logic [`AFU_DATA_BITS-1:0] mem_cmd_data,
  input logic                      mmio_read,
  input logic                      mmio_rdata_valid,
  input logic                      job_done,
  input logic                      cu_start,
  input logic                      cu_done
);

  int   failures = 0;
  logic cu_active;

  // Compute unit owns the port from cu_start to cu_done
  always_ff @(posedge clock) begin
    if (reset) begin
      cu_active <= 1'b0;
    end else if (cu_start) begin
      cu_active <= 1'b1;
    end else if (cu_done) begin
      cu_active <= 1'b0;
    end
  end

  cmd_held: assert property (@(posedge clock) disable iff (reset)
    mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd_write)
      && $stable(mem_cmd_addr) && $stable(mem_cmd_tag) && $stable(mem_cmd_data))
  else begin
    failures++;
    $error("Memory command changed while stalled");
  end

  // Read data one cycle after each read, and only then
  mmio_valid_set: assert property (@(posedge clock) disable iff (reset)
    mmio_read |=> mmio_rdata_valid)
  else begin
    failures++;
    $error("mmio_rdata_valid missing one cycle after a read");
  end

  mmio_valid_clear: assert property (@(posedge clock) disable iff (reset)
    !mmio_read |=> !mmio_rdata_valid)
  else begin
    failures++;
    $error("mmio_rdata_valid high without a read");
  end

  no_wed_tag: assert property (@(posedge clock) disable iff (reset)
    mem_cmd_valid && cu_active |-> mem_cmd_tag != tag_t'(0))
  else begin
    failures++;
    $error("Tag 0 used by a compute unit command");
  end

  done_pulse: assert property (@(posedge clock) disable iff (reset)
    job_done |=> !job_done)
  else begin
    failures++;
    $error("job_done high for two cycles");
  end

endmodule

bind afu_top afu_assertions assertions_inst (
  .clock           (clock),
  .reset           (reset),
  .mem_cmd_valid   (mem_cmd_valid),
  .mem_cmd_ready   (mem_cmd_ready),
  .mem_cmd_write   (mem_cmd_write),
  .mem_cmd_addr    (mem_cmd_addr),
  .mem_cmd_tag     (mem_cmd_tag),
  .mem_cmd_data    (mem_cmd_data),
  .mmio_read       (mmio_read),
  .mmio_rdata_valid(mmio_rdata_valid),
  .job_done        (job_done),
  .cu_start        (cu_start),
  .cu_done         (cu_done)
);

// File: afu_tb.sv
// AFU testbench
`timescale 1ns/1ps
`include "afu_params.svh"

module afu_tb import afu_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [63:0] STATUS_DONE = 64'd1 << `AFU_STATUS_DONE;
  localparam logic [63:0] STATUS_OPCODE = 64'd1 << `AFU_ERR_OPCODE;
  localparam logic [63:0] STATUS_RESPONSE = 64'd1 << `AFU_ERR_RESPONSE;

  typedef struct packed {
    logic                      write;
    tag_t                      tag;
    logic [`AFU_ADDR_BITS-1:0] addr;
  } mem_req_t;

  logic                           clock;
  logic                           reset;
  logic                           job_valid;
  logic                           job_ready;
  job_word_t                      job_word;
  logic                           job_done;
  logic                           mem_cmd_valid;
  logic                           mem_cmd_ready = 1'b0;
  logic                           mem_cmd_write;
  logic [`AFU_ADDR_BITS-1:0]      mem_cmd_addr;
  tag_t                           mem_cmd_tag;
  logic [`AFU_DATA_BITS-1:0]      mem_cmd_data;
  logic                           mem_rsp_valid = 1'b0;
  tag_t                           mem_rsp_tag = '0;
  logic [`AFU_DATA_BITS-1:0]      mem_rsp_data = '0;
  logic                           mem_rsp_error = 1'b0;
  logic                           mmio_read;
  logic [`AFU_MMIO_ADDR_BITS-1:0] mmio_addr;
  logic                           mmio_rdata_valid;
  logic [`AFU_DATA_BITS-1:0]      mmio_rdata;

  // Host memory indexed by the low address byte
  logic [`AFU_DATA_BITS-1:0] mem [0:255];
  mem_req_t                  pending[$];
  int                        response_count = 0;
  int                        error_target = -1;

  afu_top dut (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  //////////////////////////////
  // Memory model
  //////////////////////////////

  // Random stalls, random delays and random response order
  always @(posedge clock) begin
    int       pick;
    mem_req_t req;
    mem_req_t incoming;
    if (reset) begin
      mem_cmd_ready <= 1'b0;
      mem_rsp_valid <= 1'b0;
      pending.delete();
    end else begin
      mem_rsp_valid <= 1'b0;
      mem_rsp_error <= 1'b0;
      if (pending.size() > 0 && $urandom_range(0, 2) != 0) begin
        pick = $urandom_range(0, pending.size() - 1);
        req = pending[pick];
        pending.delete(pick);
        mem_rsp_valid <= 1'b1;
        mem_rsp_tag   <= req.tag;
        mem_rsp_data  <= req.write ? '0 : mem[req.addr[7:0]];
        mem_rsp_error <= response_count == error_target;
        response_count++;
      end
      if (mem_cmd_valid && mem_cmd_ready) begin
        if (mem_cmd_write) begin
          mem[mem_cmd_addr[7:0]] = mem_cmd_data;
        end
        incoming.write = mem_cmd_write;
        incoming.tag   = mem_cmd_tag;
        incoming.addr  = mem_cmd_addr;
        pending.push_back(incoming);
      end
      mem_cmd_ready <= $urandom_range(0, 3) != 0;
    end
  end

  //////////////////////////////
  // Checks and helpers
  //////////////////////////////

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("ERROR: time %0t %s expected %h actual %h", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Stop at the first bound assertion failure
  always @(posedge clock) begin
    if (dut.assertions_inst.failures != 0) begin
      $display("A protocol assertion on afu_top failed");
      stop_on_failure();
    end
  end

  function automatic job_word_t start_word(input logic [`AFU_ADDR_BITS-1:0] wed_addr);
    job_word_t word;
    word = '0;
    word.start.opcode   = `AFU_OP_START;
    word.start.wed_addr = wed_addr;
    return word;
  endfunction

  function automatic job_word_t control_word(input logic clr_result, input logic clr_errors);
    job_word_t word;
    word = '0;
    word.control.opcode       = `AFU_OP_CONTROL;
    word.control.clear_result = clr_result;
    word.control.clear_errors = clr_errors;
    return word;
  endfunction

  function automatic logic [63:0] wed_word(input logic [23:0] src, input logic [23:0] dst,
                                           input logic [15:0] count);
    logic [63:0] word;
    word = '0;
    word[`AFU_WED_SRC_HI:`AFU_WED_SRC_LO] = src;
    word[`AFU_WED_DST_HI:`AFU_WED_DST_LO] = dst;
    word[`AFU_WED_CNT_HI:`AFU_WED_CNT_LO] = count;
    return word;
  endfunction

  // Wrapping 64-bit sum of the source words
  function automatic logic [63:0] expected_sum(input logic [23:0] src, input int count);
    logic [63:0] total;
    logic [23:0] addr;
    total = '0;
    for (int n = 0; n < count; n++) begin
      addr  = src + 24'(n);
      total = total + mem[addr[7:0]];
    end
    return total;
  endfunction

  task automatic send_job(input job_word_t word);
    int waited;
    waited = 0;
    job_valid <= 1'b1;
    job_word  <= word;
    do begin
      @(posedge clock);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("Timeout while the job word waited for job_ready");
        stop_on_failure();
      end
    end while (!job_ready);
    job_valid <= 1'b0;
  endtask

  task automatic wait_job_done();
    int waited;
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("Timeout while waiting for job_done");
        stop_on_failure();
      end
    end while (!job_done);
  endtask

  // Read data comes back exactly one cycle after the read
  task automatic check_mmio(input logic [1:0] addr, input logic [63:0] expected,
                            input string name);
    mmio_read <= 1'b1;
    mmio_addr <= addr;
    @(posedge clock);
    mmio_read <= 1'b0;
    @(posedge clock);
    check_value("mmio_rdata_valid", 64'd1, 64'(mmio_rdata_valid));
    check_value(name, expected, mmio_rdata);
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) @(posedge clock);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    logic [63:0] expected;
    void'($urandom(32'h71d3));
    job_valid <= 1'b0;
    job_word  <= '0;
    mmio_read <= 1'b0;
    mmio_addr <= '0;
    reset     <= 1'b1;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {$urandom(), $urandom()};
    end
    mem[8'h10] = wed_word(24'h40, 24'h80, 16'd20);
    mem[8'h11] = wed_word(24'h60, 24'h81, 16'd0);
    mem[8'h12] = wed_word(24'h48, 24'h82, 16'd5);
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    // Quiet after reset
    check_value("job_done", 64'd0, 64'(job_done));
    check_value("mem_cmd_valid", 64'd0, 64'(mem_cmd_valid));
    check_value("mmio_rdata_valid", 64'd0, 64'(mmio_rdata_valid));
    check_value("job_ready", 64'd1, 64'(job_ready));
    check_mmio(`AFU_MMIO_STATUS, 64'd0, "mmio status");
    check_mmio(`AFU_MMIO_SUM, 64'd0, "mmio sum");
    check_mmio(`AFU_MMIO_JOBS, 64'd0, "mmio jobs");

    // Long job holds off a second start word
    expected = expected_sum(24'h40, 20);
    send_job(start_word(24'h10));
    job_word <= start_word(24'h11);
    @(posedge clock);
    check_value("job_ready", 64'd0, 64'(job_ready));
    wait_job_done();
    check_value("mem[80]", expected, mem[8'h80]);
    check_mmio(`AFU_MMIO_SUM, expected, "mmio sum");
    check_mmio(`AFU_MMIO_JOBS, 64'd1, "mmio jobs");
    check_mmio(`AFU_MMIO_STATUS, STATUS_DONE, "mmio status");

    // Zero count writes zero
    send_job(start_word(24'h11));
    wait_job_done();
    check_value("mem[81]", 64'd0, mem[8'h81]);
    check_mmio(`AFU_MMIO_SUM, 64'd0, "mmio sum");
    check_mmio(`AFU_MMIO_JOBS, 64'd2, "mmio jobs");

    // Bad opcode then clear the errors
    send_job(job_word_t'({4'hf, 60'd0}));
    idle_cycles(2);
    check_mmio(`AFU_MMIO_STATUS, STATUS_DONE | STATUS_OPCODE, "mmio status");
    send_job(control_word(1'b0, 1'b1));
    idle_cycles(2);
    check_mmio(`AFU_MMIO_STATUS, STATUS_DONE, "mmio status");

    // Next response carries an error but the job still ends
    error_target = response_count;
    expected = expected_sum(24'h48, 5);
    send_job(start_word(24'h12));
    wait_job_done();
    check_value("mem[82]", expected, mem[8'h82]);
    check_mmio(`AFU_MMIO_SUM, expected, "mmio sum");
    check_mmio(`AFU_MMIO_JOBS, 64'd3, "mmio jobs");
    check_mmio(`AFU_MMIO_STATUS, STATUS_DONE | STATUS_RESPONSE, "mmio status");

    // Clearing the result keeps the sticky error
    send_job(control_word(1'b1, 1'b0));
    idle_cycles(2);
    check_mmio(`AFU_MMIO_SUM, 64'd0, "mmio sum");
    check_mmio(`AFU_MMIO_JOBS, 64'd0, "mmio jobs");
    check_mmio(`AFU_MMIO_STATUS, STATUS_RESPONSE, "mmio status");

    check_mmio(2'd3, 64'd0, "mmio unknown address");
    idle_cycles(2);

    if (dut.assertions_inst.failures != 0) begin
      $display("A protocol assertion on afu_top failed");
      stop_on_failure();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: build.f
+incdir+.
afu_pkg.sv
job_decode.sv
command_arbiter.sv
cu_execute.sv
result_control.sv
afu_top.sv
afu_assertions.sv
afu_tb.sv

// File: Bender.yml
package:
  name: afu

sources:
  - include_dirs:
      - .
    files:
      - afu_pkg.sv
      - job_decode.sv
      - command_arbiter.sv
      - cu_execute.sv
      - result_control.sv
      - afu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - afu_assertions.sv
      - afu_tb.sv
